/* common/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// integer datapath width
`define XLEN 32

// register file addressing
`define REG_AW 5

// x0 included, though it holds no storage
`define NUM_REGS 32

`endif

/* common/isa_pkg.sv */
`include "core_config.svh"

package isa_pkg;

    // major opcodes of the integer ALU subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register
        OP_IMM = 7'b0010011   // register-immediate
    } opcode_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 codes
    localparam logic [6:0] F7_NORMAL = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB and SRA

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]        imm;  // funct7 and shamt for shifts
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } i_type_t;

    // one instruction word, read as R or I format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

endpackage

/* common/pipe_pkg.sv */
`include "core_config.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        logic               valid;
        logic               illegal;
        logic               we;       // low for x0 and illegal words
        logic [`REG_AW-1:0] rd;
        alu_op_e            op;
        logic [`XLEN-1:0]   op1;
        logic [`XLEN-1:0]   op2;      // register or sign-extended imm
    } dec_info_t;

    // execute -> writeback / retire
    typedef struct packed {
        logic               valid;
        logic               illegal;
        logic               we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_info_t;

endpackage

/* rtl/gpr.sv */
`include "core_config.svh"

module gpr (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::wb_info_t  wb_i,
    input  logic [`REG_AW-1:0]  raddr1_i,
    input  logic [`REG_AW-1:0]  raddr2_i,
    output logic [`XLEN-1:0]    rdata1_o,
    output logic [`XLEN-1:0]    rdata2_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int k = 1; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_i.valid && wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // async read, x0 reads zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* rtl/idu.sv */
`include "core_config.svh"

module idu (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 inst_valid_i,
    input  isa_pkg::inst_u       inst_i,
    input  logic [`XLEN-1:0]     rdata1_i,
    input  logic [`XLEN-1:0]     rdata2_i,
    input  pipe_pkg::wb_info_t   ex_fwd_i,   // result being computed now
    input  pipe_pkg::wb_info_t   wb_fwd_i,   // result written at next edge
    output logic [`REG_AW-1:0]   raddr1_o,
    output logic [`REG_AW-1:0]   raddr2_o,
    output pipe_pkg::dec_info_t  dec_o
);

    pipe_pkg::alu_op_e   alu_op;
    pipe_pkg::dec_info_t dec_d;
    logic                illegal;
    logic                is_imm;
    logic [`XLEN-1:0]    imm_sext;
    logic [`XLEN-1:0]    rs1_val;
    logic [`XLEN-1:0]    rs2_val;

    // newest producer wins
    function automatic logic [`XLEN-1:0] bypass(
        input logic [`REG_AW-1:0] addr,
        input logic [`XLEN-1:0]   rf_data,
        input pipe_pkg::wb_info_t ex,
        input pipe_pkg::wb_info_t wb
    );
        if (addr == '0) return '0;
        if (ex.valid && ex.we && (ex.rd == addr)) return ex.data;
        if (wb.valid && wb.we && (wb.rd == addr)) return wb.data;
        return rf_data;
    endfunction

    // alt selects SUB / SRA on the shared funct3 codes
    function automatic pipe_pkg::alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            isa_pkg::F3_ADD_SUB: return alt ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     return pipe_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     return pipe_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    return pipe_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     return pipe_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: return alt ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
            isa_pkg::F3_OR:      return pipe_pkg::ALU_OR;
            default:             return pipe_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        alu_op  = pipe_pkg::ALU_ADD;
        illegal = 1'b0;
        is_imm  = 1'b0;
        case (inst_i.r.opcode)
            isa_pkg::OP: begin
                alu_op = f3_to_op(inst_i.r.funct3, inst_i.r.funct7 == isa_pkg::F7_ALT);
                // alt form only exists for SUB and SRA
                if (inst_i.r.funct7 == isa_pkg::F7_ALT) begin
                    illegal = (inst_i.r.funct3 != isa_pkg::F3_ADD_SUB) &&
                              (inst_i.r.funct3 != isa_pkg::F3_SRL_SRA);
                end else begin
                    illegal = (inst_i.r.funct7 != isa_pkg::F7_NORMAL);
                end
            end
            isa_pkg::OP_IMM: begin
                is_imm = 1'b1;
                alu_op = f3_to_op(inst_i.i.funct3,
                                  (inst_i.i.funct3 == isa_pkg::F3_SRL_SRA) && inst_i.i.imm[10]);
                if (inst_i.i.funct3 == isa_pkg::F3_SLL) begin
                    illegal = (inst_i.i.imm[11:5] != isa_pkg::F7_NORMAL);
                end else if (inst_i.i.funct3 == isa_pkg::F3_SRL_SRA) begin
                    illegal = (inst_i.i.imm[11:5] != isa_pkg::F7_NORMAL) &&
                              (inst_i.i.imm[11:5] != isa_pkg::F7_ALT);
                end
            end
            default: illegal = 1'b1;  // loads, branches, system...
        endcase
    end

    assign imm_sext = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign raddr1_o = inst_i.r.rs1;
    assign raddr2_o = inst_i.r.rs2;
    assign rs1_val  = bypass(raddr1_o, rdata1_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val  = bypass(raddr2_o, rdata2_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        dec_d.valid   = inst_valid_i;
        dec_d.illegal = illegal;
        dec_d.we      = !illegal && (inst_i.r.rd != '0);
        dec_d.rd      = inst_i.r.rd;
        dec_d.op      = alu_op;
        dec_d.op1     = rs1_val;
        dec_d.op2     = is_imm ? imm_sext : rs2_val;
    end

    always_ff @(posedge clk_i) begin
        dec_o <= dec_d;
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
        end
    end

endmodule

/* rtl/exu.sv */
`include "core_config.svh"

module exu (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  pipe_pkg::dec_info_t  dec_i,
    output pipe_pkg::wb_info_t   ex_fwd_o,  // same-cycle result for bypass
    output pipe_pkg::wb_info_t   wb_o
);

    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;
    logic             lt_s;
    logic             lt_u;

    assign shamt = dec_i.op2[4:0];
    assign lt_s  = $signed(dec_i.op1) < $signed(dec_i.op2);
    assign lt_u  = dec_i.op1 < dec_i.op2;

    always_comb begin
        case (dec_i.op)
            pipe_pkg::ALU_ADD:  result = dec_i.op1 + dec_i.op2;
            pipe_pkg::ALU_SUB:  result = dec_i.op1 - dec_i.op2;
            pipe_pkg::ALU_SLL:  result = dec_i.op1 << shamt;
            pipe_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
            pipe_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_u};
            pipe_pkg::ALU_XOR:  result = dec_i.op1 ^ dec_i.op2;
            pipe_pkg::ALU_SRL:  result = dec_i.op1 >> shamt;
            pipe_pkg::ALU_SRA:  result = $signed(dec_i.op1) >>> shamt;
            pipe_pkg::ALU_OR:   result = dec_i.op1 | dec_i.op2;
            pipe_pkg::ALU_AND:  result = dec_i.op1 & dec_i.op2;
            default:            result = '0;
        endcase
    end

    always_comb begin
        ex_fwd_o.valid   = dec_i.valid;
        ex_fwd_o.illegal = dec_i.illegal;
        ex_fwd_o.we      = dec_i.we;
        ex_fwd_o.rd      = dec_i.rd;
        ex_fwd_o.data    = result;
    end

    // writeback stage register
    always_ff @(posedge clk_i) begin
        wb_o <= ex_fwd_o;
        if (!rst_n_i) begin
            wb_o.valid <= 1'b0;
        end
    end

endmodule

/* rtl/cpu_top.sv */
`include "core_config.svh"

module cpu_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  logic [31:0]        inst_i,
    output logic               retire_valid_o,
    output logic               retire_illegal_o,
    output logic [`REG_AW-1:0] retire_rd_o,
    output logic [`XLEN-1:0]   retire_data_o
);

    logic [`REG_AW-1:0]  raddr1;
    logic [`REG_AW-1:0]  raddr2;
    logic [`XLEN-1:0]    rdata1;
    logic [`XLEN-1:0]    rdata2;
    pipe_pkg::dec_info_t dec;
    pipe_pkg::wb_info_t  ex_fwd;
    pipe_pkg::wb_info_t  wb;

    idu u_idu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb),      // also the gpr write port
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .dec_o        (dec)
    );

    exu u_exu (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .dec_i    (dec),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb)
    );

    gpr u_gpr (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    // retire port
    assign retire_valid_o   = wb.valid;
    assign retire_illegal_o = wb.illegal;
    assign retire_rd_o      = wb.rd;
    assign retire_data_o    = wb.data;

endmodule

/* tests/tb_cpu_top.sv */
`include "core_config.svh"

module tb_cpu_top;

    localparam int MAX_CYCLES = 2000;  // about 270 issue and idle cycles in all

    typedef struct packed {
        logic               illegal;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
        logic [31:0]        due;  // cycle count at retirement
    } retire_t;

    logic               clk;
    logic               rst_n;
    logic               inst_valid;
    logic [31:0]        inst;
    logic               retire_valid;
    logic               retire_illegal;
    logic [`REG_AW-1:0] retire_rd;
    logic [`XLEN-1:0]   retire_data;

    logic [`XLEN-1:0] ref_regs [0:`NUM_REGS-1];  // architectural register model
    retire_t          exp_q [$];
    retire_t          head;
    logic [31:0]      cycles = '0;
    integer           seed = 28;
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               err_base = 0;
    string            cur_test = "init";

    cpu_top DUT (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .inst_valid_i     (inst_valid),
        .inst_i           (inst),
        .retire_valid_o   (retire_valid),
        .retire_illegal_o (retire_illegal),
        .retire_rd_o      (retire_rd),
        .retire_data_o    (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // retire monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("%s: retirement seen with no instruction outstanding", cur_test);
                errors++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                check_eq("cycle", head.due, cycles);
                check_eq("illegal", 32'(head.illegal), 32'(retire_illegal));
                if (!head.illegal) begin  // rd and data only mean something here
                    check_eq("rd", 32'(head.rd), 32'(retire_rd));
                    check_eq("data", head.data, retire_data);
                end
            end
        end else if (rst_n && exp_q.size() != 0) begin
            assert (exp_q[0].due > cycles) else begin
                $display("%s: instruction did not retire on time", cur_test);
                errors++;
                head = exp_q.pop_front();
            end
        end
    end

    // RV32I ALU rules where alt selects SUB and SRA
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // retirement due two cycles after the drive
    task automatic send(input logic [31:0] word, input logic ill,
                        input logic [4:0] rd, input logic [31:0] data);
        retire_t e;
        e.illegal = ill;
        e.rd      = rd;
        e.data    = data;
        e.due     = cycles + 32'd2;
        exp_q.push_back(e);
        if (!ill && rd != '0) begin
            ref_regs[rd] = data;
        end
        inst_valid = 1'b1;
        inst       = word;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic op_imm(input logic [2:0] f3, input int rd, input int rs1,
                          input logic [11:0] imm);
        isa_pkg::inst_u w;
        logic           ill;
        logic [31:0]    res;
        w.i.imm    = imm;
        w.i.rs1    = 5'(rs1);
        w.i.funct3 = f3;
        w.i.rd     = 5'(rd);
        w.i.opcode = isa_pkg::OP_IMM;
        // shift immediates allow upper bits 0, or 0100000 for SRAI
        ill = (f3 == isa_pkg::F3_SLL && imm[11:5] != 7'h00) ||
              (f3 == isa_pkg::F3_SRL_SRA && imm[11:5] != 7'h00 && imm[11:5] != 7'h20);
        res = alu_model(f3, f3 == isa_pkg::F3_SRL_SRA && imm[10], ref_regs[rs1],
                        {{20{imm[11]}}, imm});
        send(w, ill, 5'(rd), res);
    endtask

    task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                          input int rs1, input int rs2);
        isa_pkg::inst_u w;
        logic           alt;
        logic           ill;
        w.r.funct7 = f7;
        w.r.rs2    = 5'(rs2);
        w.r.rs1    = 5'(rs1);
        w.r.funct3 = f3;
        w.r.rd     = 5'(rd);
        w.r.opcode = isa_pkg::OP;
        alt = (f7 == isa_pkg::F7_ALT);
        ill = !(f7 == isa_pkg::F7_NORMAL ||
                (alt && (f3 == isa_pkg::F3_ADD_SUB || f3 == isa_pkg::F3_SRL_SRA)));
        send(w, ill, 5'(rd), alu_model(f3, alt, ref_regs[rs1], ref_regs[rs2]));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            inst_valid = 1'b0;
            inst       = $random(seed);  // must be ignored
            @(posedge clk);
            #1;
        end
    endtask

    // ADDI SLLI ORI chain building 11 + 11 + 10 bits
    task automatic load_const(input int rd, input logic [31:0] v);
        op_imm(isa_pkg::F3_ADD_SUB, rd, 0, {1'b0, v[31:21]});
        op_imm(isa_pkg::F3_SLL, rd, rd, 12'd11);
        op_imm(isa_pkg::F3_OR, rd, rd, {1'b0, v[20:10]});
        op_imm(isa_pkg::F3_SLL, rd, rd, 12'd10);
        op_imm(isa_pkg::F3_OR, rd, rd, {2'b0, v[9:0]});
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = errors;
        tests++;
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        $display("%-12s done, %0d errors", cur_test, errors - err_base);
    endtask

    task automatic reset_test();
        start_test("reset");
        idle(8);
        for (int r = 0; r < `NUM_REGS; r++) begin
            op_imm(isa_pkg::F3_ADD_SUB, r, r, 12'h000);  // read back every register
        end
        finish_test();
    endtask

    task automatic imm_test();
        start_test("imm");
        op_imm(isa_pkg::F3_ADD_SUB, 1, 0, 12'h123);
        op_imm(isa_pkg::F3_ADD_SUB, 2, 0, 12'hF85);  // -123
        op_imm(isa_pkg::F3_SLT, 3, 2, 12'h000);
        op_imm(isa_pkg::F3_SLT, 11, 1, 12'h800);
        op_imm(isa_pkg::F3_SLTU, 4, 2, 12'h005);
        op_imm(isa_pkg::F3_SLTU, 4, 2, 12'hFFF);     // imm sign-extends to all ones
        op_imm(isa_pkg::F3_XOR, 5, 1, 12'hFFF);
        op_imm(isa_pkg::F3_OR, 6, 2, 12'h07A);
        op_imm(isa_pkg::F3_AND, 7, 2, 12'hF0F);
        op_imm(isa_pkg::F3_SLL, 8, 1, 12'h014);
        op_imm(isa_pkg::F3_SRL_SRA, 9, 2, 12'h004);
        op_imm(isa_pkg::F3_SRL_SRA, 10, 2, 12'h404); // SRAI on a negative value
        finish_test();
    endtask

    task automatic reg_test();
        logic [31:0] v;
        start_test("reg_reg");
        for (int r = 1; r <= 8; r++) begin
            v = $random(seed);
            load_const(r, v);
        end
        for (int p = 1; p <= 7; p += 2) begin
            for (int f = 0; f < 8; f++) begin
                op_reg(isa_pkg::F7_NORMAL, 3'(f), 16 + f, p, p + 1);
            end
            op_reg(isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, 24, p, p + 1);
            op_reg(isa_pkg::F7_ALT, isa_pkg::F3_SRL_SRA, 25, p + 1, p);
        end
        op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_SLT, 26, 1, 1);
        finish_test();
    endtask

    task automatic chain_test();
        start_test("chain");
        op_imm(isa_pkg::F3_ADD_SUB, 1, 0, 12'h005);
        op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_ADD_SUB, 2, 1, 1);
        op_reg(isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, 3, 2, 1);  // distance 1 and 2
        op_imm(isa_pkg::F3_XOR, 3, 3, 12'hABC);
        op_reg(isa_pkg::F7_ALT, isa_pkg::F3_SRL_SRA, 4, 3, 1);
        for (int i = 0; i < 12; i++) begin
            op_imm(isa_pkg::F3_ADD_SUB, 11, 10, 12'(i * 37));
            op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_ADD_SUB, 10, 10, 11);
        end
        op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_SLL, 12, 10, 10);
        finish_test();
    endtask

    task automatic x0_test();
        start_test("x0_illegal");
        op_imm(isa_pkg::F3_ADD_SUB, 0, 0, 12'h055);
        op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_OR, 0, 1, 2);
        op_imm(isa_pkg::F3_ADD_SUB, 5, 0, 12'h000);
        op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_ADD_SUB, 6, 0, 0);
        op_imm(isa_pkg::F3_ADD_SUB, 7, 0, 12'h011);
        send(32'h0000_2383, 1'b1, 5'd0, 32'd0);  // lw x7, 0(x0)
        op_reg(7'h01, isa_pkg::F3_ADD_SUB, 7, 1, 2);
        op_imm(isa_pkg::F3_SLL, 7, 7, 12'h401);
        send(32'h0000_0063, 1'b1, 5'd0, 32'd0);  // beq x0, x0, 0
        op_imm(isa_pkg::F3_ADD_SUB, 8, 7, 12'h000);
        finish_test();
    endtask

    task automatic gap_test();
        logic [31:0] r;
        start_test("gaps");
        op_imm(isa_pkg::F3_ADD_SUB, 1, 0, 12'h001);
        idle(3);
        op_imm(isa_pkg::F3_ADD_SUB, 2, 1, 12'h7FF);
        idle(1);
        op_reg(isa_pkg::F7_NORMAL, isa_pkg::F3_ADD_SUB, 3, 2, 1);
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            if (r[0]) begin
                idle(int'(r[2:1]) + 1);
            end
            op_reg(isa_pkg::F7_NORMAL, r[5:3], 5 + (i % 4), 4 + (i % 4), 3 + (i % 4));
        end
        finish_test();
    endtask

    initial begin
        for (int r = 0; r < `NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_test();
        imm_test();
        reg_test();
        chain_test();
        x0_test();
        gap_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* cpu_top.f */
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/gpr.sv
rtl/idu.sv
rtl/exu.sv
rtl/cpu_top.sv
tests/tb_cpu_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_cpu_top
FILELIST  := cpu_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard common/*.sv common/*.svh rtl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
